// ==== design/nnPkg.sv ====
package nnPkg;

	// ==================================================
	// layer geometry and fixed point
	// ==================================================
	localparam int numInputs = 10;
	localparam int numNeurons = 4;
	localparam int dataWidth = 8;
	localparam int biasWidth = 16;
	localparam int accWidth = 23;
	localparam int fracShift = 6; // result is acc[13:6], bit 5 rounds
	localparam logic [dataWidth-1:0] satValue = dataWidth'(127);

	typedef logic signed [2*dataWidth-1:0] prodType;
	typedef logic signed [accWidth-1:0] accType;

	// ==================================================
	// register map
	// ==================================================
	localparam int addrWidth = 8;
	localparam int busWidth = 32;
	localparam int neuronStride = 64; // bytes per neuron block
	localparam int strideBits = $clog2(neuronStride);
	localparam int biasOffset = 40; // weights sit at 4*i below this

	// neuron 0 comes up as the reference node, the rest blank
	localparam logic signed [dataWidth-1:0] resetWeights [numNeurons][numInputs] = '{
		'{-8'sd14, -8'sd56, 8'sd48, -8'sd40, -8'sd16, -8'sd6, 8'sd12, -8'sd14, -8'sd6, 8'sd34},
		'{default: '0},
		'{default: '0},
		'{default: '0}
	};

	localparam logic signed [biasWidth-1:0] resetBias [numNeurons] = '{
		0: 16'sd1024,
		default: '0
	};

	typedef enum logic [1:0]
	{
		respOkay = 2'b00,
		respSlvErr = 2'b10
	} respType;

endpackage

// ==== design/axiLiteIf.sv ====
`timescale 1ns/10ps

interface axiLiteIf;
	logic [nnPkg::addrWidth-1:0] awaddr;
	logic awvalid;
	logic awready;
	logic [nnPkg::busWidth-1:0] wdata;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;
	logic [nnPkg::addrWidth-1:0] araddr;
	logic arvalid;
	logic arready;
	logic [nnPkg::busWidth-1:0] rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;

	modport master
	(
		output awaddr, awvalid, wdata, wvalid, bready, araddr, arvalid, rready,
		input awready, wready, bresp, bvalid, arready, rdata, rresp, rvalid
	);

	modport slave
	(
		input awaddr, awvalid, wdata, wvalid, bready, araddr, arvalid, rready,
		output awready, wready, bresp, bvalid, arready, rdata, rresp, rvalid
	);
endinterface

// ==== design/neuronCore.sv ====
`timescale 1ns/10ps

module neuronCore
(
	input logic clk,
	input logic reset,
	input logic [nnPkg::numInputs-1:0][nnPkg::dataWidth-1:0] act,
	input logic [nnPkg::numInputs-1:0][nnPkg::dataWidth-1:0] weight,
	input logic signed [nnPkg::biasWidth-1:0] bias,
	output logic [nnPkg::dataWidth-1:0] result
);
	logic [nnPkg::numInputs-1:0][nnPkg::dataWidth-1:0] actReg;
	nnPkg::prodType prod [nnPkg::numInputs];
	nnPkg::accType sumNext;
	nnPkg::accType sum;

	// ==================================================
	// stage 1: capture activations
	// ==================================================
	always_ff @(posedge clk)
	begin
		if (reset)
			actReg <= '0;
		else
			actReg <= act;
	end

	// ==================================================
	// stage 2: multiply and accumulate
	// ==================================================
	always_comb
	begin
		for (int i = 0; i < nnPkg::numInputs; i++)
		begin
			prod[i] = nnPkg::prodType'($signed(actReg[i])) * nnPkg::prodType'($signed(weight[i]));
		end
	end

	// bias seeds the sum
	always_comb
	begin
		sumNext = nnPkg::accType'(bias);
		for (int i = 0; i < nnPkg::numInputs; i++)
		begin
			sumNext = sumNext + nnPkg::accType'(prod[i]);
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			sum <= '0;
		else
			sum <= sumNext;
	end

	// ==================================================
	// stage 3: relu, saturate, round
	// ==================================================
	always_ff @(posedge clk)
	begin
		if (reset)
			result <= '0;
		else if (sum[nnPkg::accWidth-1])
			result <= '0; // relu
		else if (sum[nnPkg::accWidth-2:nnPkg::fracShift+nnPkg::dataWidth-1] != '0)
			result <= nnPkg::satValue;
		else
			// 127 plus a round bit gives 128, same as the reference node
			result <= sum[nnPkg::fracShift+nnPkg::dataWidth-1:nnPkg::fracShift]
				+ {{(nnPkg::dataWidth-1){1'b0}}, sum[nnPkg::fracShift-1]};
	end

endmodule

// ==== design/denseLayer.sv ====
`timescale 1ns/10ps

module denseLayer
(
	input logic clk,
	input logic reset,
	input logic [nnPkg::numInputs-1:0][nnPkg::dataWidth-1:0] inVec,
	input logic inValid,
	input logic [nnPkg::numNeurons-1:0][nnPkg::numInputs-1:0][nnPkg::dataWidth-1:0] weights,
	input logic [nnPkg::numNeurons-1:0][nnPkg::biasWidth-1:0] biases,
	output logic [nnPkg::numNeurons-1:0][nnPkg::dataWidth-1:0] outVec,
	output logic outValid
);
	logic [2:0] validPipe; // one bit per core stage

	// every neuron sees the same activations
	generate
		for (genvar n = 0; n < nnPkg::numNeurons; n++)
		begin : neuronGen
			neuronCore core
			(
				.clk(clk),
				.reset(reset),
				.act(inVec),
				.weight(weights[n]),
				.bias(biases[n]),
				.result(outVec[n])
			);
		end
	endgenerate

	always_ff @(posedge clk)
	begin
		if (reset)
			validPipe <= '0;
		else
			validPipe <= {validPipe[1:0], inValid};
	end

	assign outValid = validPipe[2];

endmodule

// ==== design/layerRegs.sv ====
`timescale 1ns/10ps

module layerRegs
(
	input logic clk,
	input logic reset,
	axiLiteIf.slave bus,
	output logic [nnPkg::numNeurons-1:0][nnPkg::numInputs-1:0][nnPkg::dataWidth-1:0] weights,
	output logic [nnPkg::numNeurons-1:0][nnPkg::biasWidth-1:0] biases
);
	logic [nnPkg::addrWidth-nnPkg::strideBits-1:0] wrNeuron;
	logic [nnPkg::addrWidth-nnPkg::strideBits-1:0] rdNeuron;
	logic [nnPkg::strideBits-3:0] wrIndex;
	logic [nnPkg::strideBits-3:0] rdIndex;
	logic writeStart;
	logic readStart;
	logic [nnPkg::busWidth-1:0] readWord;

	// ==================================================
	// address decode
	// ==================================================
	function automatic logic addrIsBias(input logic [nnPkg::addrWidth-1:0] addr);
		return int'(addr[nnPkg::strideBits-1:0]) == nnPkg::biasOffset;
	endfunction

	function automatic logic addrMapped(input logic [nnPkg::addrWidth-1:0] addr);
		logic neuronOk;
		logic weightOk;
		neuronOk = int'(addr[nnPkg::addrWidth-1:nnPkg::strideBits]) < nnPkg::numNeurons;
		weightOk = (addr[1:0] == 2'b00)
			&& (int'(addr[nnPkg::strideBits-1:0]) < nnPkg::numInputs * 4);
		return neuronOk && (weightOk || addrIsBias(addr));
	endfunction

	assign wrNeuron = bus.awaddr[nnPkg::addrWidth-1:nnPkg::strideBits];
	assign wrIndex = bus.awaddr[nnPkg::strideBits-1:2];
	assign rdNeuron = bus.araddr[nnPkg::addrWidth-1:nnPkg::strideBits];
	assign rdIndex = bus.araddr[nnPkg::strideBits-1:2];

	// ==================================================
	// write channel
	// ==================================================
	assign writeStart = bus.awvalid && bus.wvalid && !bus.awready && !bus.bvalid;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			bus.awready <= 1'b0;
			bus.wready <= 1'b0;
			bus.bvalid <= 1'b0;
		end
		else
		begin
			bus.awready <= writeStart; // single-cycle pulse
			bus.wready <= writeStart;
			if (bus.awready)
				bus.bvalid <= 1'b1;
			else if (bus.bready)
				bus.bvalid <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (bus.awready)
			bus.bresp <= addrMapped(bus.awaddr) ? nnPkg::respOkay : nnPkg::respSlvErr;
	end

	// coefficient store, written as ready goes up
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int n = 0; n < nnPkg::numNeurons; n++)
			begin
				biases[n] <= nnPkg::resetBias[n];
				for (int i = 0; i < nnPkg::numInputs; i++)
				begin
					weights[n][i] <= nnPkg::resetWeights[n][i];
				end
			end
		end
		else if (writeStart && addrMapped(bus.awaddr))
		begin
			if (addrIsBias(bus.awaddr))
				biases[wrNeuron] <= bus.wdata[nnPkg::biasWidth-1:0];
			else
				weights[wrNeuron][wrIndex] <= bus.wdata[nnPkg::dataWidth-1:0];
		end
	end

	// ==================================================
	// read channel
	// ==================================================
	assign readStart = bus.arvalid && !bus.arready && !bus.rvalid;

	// sign-extended readback, zero when unmapped
	always_comb
	begin
		readWord = '0;
		if (addrMapped(bus.araddr))
		begin
			if (addrIsBias(bus.araddr))
				readWord = {{(nnPkg::busWidth-nnPkg::biasWidth){biases[rdNeuron][nnPkg::biasWidth-1]}},
					biases[rdNeuron]};
			else
				readWord = {{(nnPkg::busWidth-nnPkg::dataWidth)
					{weights[rdNeuron][rdIndex][nnPkg::dataWidth-1]}},
					weights[rdNeuron][rdIndex]};
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			bus.arready <= 1'b0;
			bus.rvalid <= 1'b0;
		end
		else
		begin
			bus.arready <= readStart;
			if (bus.arready)
				bus.rvalid <= 1'b1;
			else if (bus.rready)
				bus.rvalid <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (bus.arready)
		begin
			bus.rdata <= readWord;
			bus.rresp <= addrMapped(bus.araddr) ? nnPkg::respOkay : nnPkg::respSlvErr;
		end
	end

endmodule

// ==== design/layerTop.sv ====
`timescale 1ns/10ps

module layerTop
(
	input logic clk,
	input logic reset,
	input logic [nnPkg::addrWidth-1:0] awaddr,
	input logic awvalid,
	output logic awready,
	input logic [nnPkg::busWidth-1:0] wdata,
	input logic [nnPkg::busWidth/8-1:0] wstrb, // ignored, registers are full words
	input logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input logic bready,
	input logic [nnPkg::addrWidth-1:0] araddr,
	input logic arvalid,
	output logic arready,
	output logic [nnPkg::busWidth-1:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input logic rready,
	input logic [nnPkg::numInputs*nnPkg::dataWidth-1:0] inVec,
	input logic inValid,
	output logic [nnPkg::numNeurons*nnPkg::dataWidth-1:0] outVec,
	output logic outValid
);
	logic [nnPkg::numNeurons-1:0][nnPkg::numInputs-1:0][nnPkg::dataWidth-1:0] weights;
	logic [nnPkg::numNeurons-1:0][nnPkg::biasWidth-1:0] biases;

	axiLiteIf regBus ();

	// ==================================================
	// master side of the config bus
	// ==================================================
	assign regBus.awaddr = awaddr;
	assign regBus.awvalid = awvalid;
	assign regBus.wdata = wdata;
	assign regBus.wvalid = wvalid;
	assign regBus.bready = bready;
	assign regBus.araddr = araddr;
	assign regBus.arvalid = arvalid;
	assign regBus.rready = rready;
	assign awready = regBus.awready;
	assign wready = regBus.wready;
	assign bresp = regBus.bresp;
	assign bvalid = regBus.bvalid;
	assign arready = regBus.arready;
	assign rdata = regBus.rdata;
	assign rresp = regBus.rresp;
	assign rvalid = regBus.rvalid;

	layerRegs regs0
	(
		.clk(clk),
		.reset(reset),
		.bus(regBus.slave),
		.weights(weights),
		.biases(biases)
	);

	denseLayer layer0
	(
		.clk(clk),
		.reset(reset),
		.inVec(inVec), // activation 0 in low byte
		.inValid(inValid),
		.weights(weights),
		.biases(biases),
		.outVec(outVec),
		.outValid(outValid)
	);

endmodule

// ==== tb/layerTop_asserts.sv ====
`timescale 1ns/10ps

module layerTop_asserts
(
	input logic clk,
	input logic reset,
	input logic awready,
	input logic wready,
	input logic bvalid,
	input logic bready,
	input logic rvalid,
	input logic rready,
	input logic inValid,
	input logic outValid
);
	int failures = 0;

	// responses are held until the master takes them
	bHeld: assert property (@(posedge clk) disable iff (reset)
		bvalid && !bready |=> bvalid)
		else
		begin
			failures++;
			$error("bvalid dropped before bready");
		end

	rHeld: assert property (@(posedge clk) disable iff (reset)
		rvalid && !rready |=> rvalid)
		else
		begin
			failures++;
			$error("rvalid dropped before rready");
		end

	readyPair: assert property (@(posedge clk) disable iff (reset)
		awready == wready)
		else
		begin
			failures++;
			$error("awready and wready out of step");
		end

	validIn: assert property (@(posedge clk) disable iff (reset)
		inValid |-> ##3 outValid)
		else
		begin
			failures++;
			$error("outValid missing three cycles after inValid");
		end

	validOut: assert property (@(posedge clk) disable iff (reset)
		outValid |-> $past(inValid, 3))
		else
		begin
			failures++;
			$error("outValid without a matching inValid");
		end

endmodule

// ==== tb/layerChecker.sv ====
`timescale 1ns/10ps

module layerChecker
(
	input logic clk,
	input logic reset,
	input logic [7:0] awaddr,
	input logic awvalid,
	input logic awready,
	input logic [31:0] wdata,
	input logic wvalid,
	input logic wready,
	input logic [1:0] bresp,
	input logic bvalid,
	input logic bready,
	input logic [31:0] rdata,
	input logic [1:0] rresp,
	input logic rvalid,
	input logic rready,
	input logic [79:0] inVec,
	input logic inValid,
	input logic [31:0] outVec,
	input logic outValid,
	input logic [31:0] expData,
	input nnPkg::respType expResp,
	output int checks,
	output int errors,
	output int pending
);
	int wCopy [4][10];
	int bCopy [4];
	logic [31:0] expQ [$];
	logic [31:0] expOut;

	// ==================================================
	// reference neuron
	// ==================================================
	function automatic logic [7:0] neuronOut(input int n, input logic [79:0] v);
		int sum;
		int a;
		sum = bCopy[n];
		for (int i = 0; i < 10; i++)
		begin
			a = $signed(v[i*8 +: 8]);
			sum = sum + a * wCopy[n][i];
		end
		if (sum < 0)
			return 8'd0; // relu
		if (sum >= 8192)
			return 8'd127;
		return 8'((sum >>> 6) + ((sum >>> 5) & 1));
	endfunction

	initial
	begin
		checks = 0;
		errors = 0;
		pending = 0;
	end

	// coefficient mirror, follows the write handshake
	always @(posedge clk)
	begin
		if (reset)
		begin
			for (int n = 0; n < 4; n++)
			begin
				bCopy[n] = int'(nnPkg::resetBias[n]);
				for (int i = 0; i < 10; i++)
					wCopy[n][i] = int'(nnPkg::resetWeights[n][i]);
			end
		end
		else if (awvalid && awready && wvalid && wready)
		begin
			if (awaddr[5:0] == 6'd40)
				bCopy[awaddr[7:6]] = $signed(wdata[15:0]);
			else if (awaddr[5:0] < 6'd40 && awaddr[1:0] == 2'b00)
				wCopy[awaddr[7:6]][awaddr[5:2]] = $signed(wdata[7:0]);
		end
	end

	always @(posedge clk)
	begin
		if (!reset && inValid)
		begin
			for (int n = 0; n < 4; n++)
				expOut[n*8 +: 8] = neuronOut(n, inVec);
			expQ.push_back(expOut);
		end
		if (!reset && outValid)
		begin
			checks++;
			if (expQ.size() == 0)
			begin
				errors++;
				$display("outValid came with no vector in flight at %0t", $time);
			end
			else if (outVec !== expQ[0])
			begin
				errors++;
				$display("** Error at %0t: outVec %h, expected %h", $time, outVec, expQ[0]);
				void'(expQ.pop_front());
			end
			else
				$display("vector ok: %h", expQ.pop_front());
		end
		if (!reset && bvalid && bready)
		begin
			checks++;
			if (bresp !== expResp)
			begin
				errors++;
				$display("** Error at %0t: bresp %b, expected %b", $time, bresp, expResp);
			end
			else
				$display("write ok: resp %b", bresp);
		end
		if (!reset && rvalid && rready)
		begin
			checks++;
			if (rdata !== expData || rresp !== expResp)
			begin
				errors++;
				$display("** Error at %0t: read %h/%b, expected %h/%b", $time,
					rdata, rresp, expData, expResp);
			end
			else
				$display("read ok: %h", rdata);
		end
		pending = expQ.size();
	end

endmodule

// ==== tb/layerTb.sv ====
`timescale 1ns/10ps

module layerTb;
	typedef enum {entWrite, entRead, entVector} entryKind;

	logic clk = 1'b0;
	logic reset = 1'b1;
	logic [7:0] awaddr = '0;
	logic awvalid = 1'b0;
	logic awready;
	logic [31:0] wdata = '0;
	logic [3:0] wstrb = 4'hF;
	logic wvalid = 1'b0;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready = 1'b0;
	logic [7:0] araddr = '0;
	logic arvalid = 1'b0;
	logic arready;
	logic [31:0] rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready = 1'b0;
	logic [79:0] inVec = '0;
	logic inValid = 1'b0;
	logic [31:0] outVec;
	logic outValid;
	logic [31:0] expData = '0;
	nnPkg::respType expResp = nnPkg::respOkay;
	int checks;
	int errors;
	int pending;

	entryKind kinds [256];
	logic [7:0] addrs [256];
	logic [31:0] datas [256];
	logic [79:0] vecs [256];
	nnPkg::respType resps [256];
	int numEntries = 0;
	int cycleCount = 0;
	int cycleLimit = 100000;
	int seed = 32'h28c1_e8bd;
	logic [31:0] written [4][11];
	logic prevVector;

	layerTop dut0 (.*);

	layerChecker chk0 (.*);

	bind layerTop layerTop_asserts asserts0 (.*);

	always #4 clk = ~clk;

	// ==================================================
	// table building
	// ==================================================
	task automatic writeEntry(input logic [7:0] a, input logic [31:0] d, input nnPkg::respType r);
		kinds[numEntries] = entWrite;
		addrs[numEntries] = a;
		datas[numEntries] = d;
		resps[numEntries] = r;
		numEntries++;
	endtask

	task automatic readEntry(input logic [7:0] a, input logic [31:0] d, input nnPkg::respType r);
		kinds[numEntries] = entRead;
		addrs[numEntries] = a;
		datas[numEntries] = d;
		resps[numEntries] = r;
		numEntries++;
	endtask

	task automatic vectorEntry(input logic [79:0] v);
		kinds[numEntries] = entVector;
		vecs[numEntries] = v;
		numEntries++;
	endtask

	function automatic logic [79:0] oneAct(input int idx, input logic [7:0] val);
		logic [79:0] v;
		v = '0;
		v[idx*8 +: 8] = val;
		return v;
	endfunction

	function automatic logic [79:0] randomVec();
		logic [95:0] r;
		r = {$random(seed), $random(seed), $random(seed)};
		return r[79:0];
	endfunction

	// ==================================================
	// bus drivers
	// ==================================================
	task automatic regWrite(input logic [7:0] a, input logic [31:0] d);
		awaddr = a;
		wdata = d;
		awvalid = 1'b1;
		wvalid = 1'b1;
		do @(negedge clk); while (!(awready && wready));
		@(negedge clk); // address and data taken on the edge just passed
		awvalid = 1'b0;
		wvalid = 1'b0;
		while (!bvalid) @(negedge clk);
		@(negedge clk); // response left waiting a cycle
		bready = 1'b1;
		@(negedge clk);
		bready = 1'b0;
	endtask

	task automatic busRead(input logic [7:0] a);
		araddr = a;
		arvalid = 1'b1;
		do @(negedge clk); while (!arready);
		@(negedge clk);
		arvalid = 1'b0;
		while (!rvalid) @(negedge clk);
		@(negedge clk); // response left waiting a cycle
		rready = 1'b1;
		@(negedge clk);
		rready = 1'b0;
	endtask

	always @(posedge clk)
	begin
		cycleCount++;
		if (cycleCount >= cycleLimit)
		begin
			$display("timeout: run stopped after %0d cycles", cycleCount);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	initial
	begin
		// reset coefficients, relu and saturation on neuron 0
		vectorEntry('0);
		vectorEntry({10{8'h01}});
		for (int k = 0; k < 3; k++)
			vectorEntry(randomVec());
		vectorEntry(oneAct(1, 8'd127));
		vectorEntry(oneAct(2, 8'd127));
		vectorEntry(oneAct(2, 8'd127) | oneAct(9, 8'd127));
		// bias-only sums on neurons 1 to 3
		writeEntry(8'h68, 32'd8191, nnPkg::respOkay);
		writeEntry(8'hA8, 32'd8192, nnPkg::respOkay);
		writeEntry(8'hE8, 32'hFFFF_FFFF, nnPkg::respOkay);
		vectorEntry('0);
		writeEntry(8'h68, 32'd100, nnPkg::respOkay);
		writeEntry(8'hA8, 32'd8160, nnPkg::respOkay);
		writeEntry(8'hE8, 32'h0000_E000, nnPkg::respOkay);
		vectorEntry(randomVec());
		readEntry(8'hE8, 32'hFFFF_E000, nnPkg::respOkay);
		// full register map
		for (int n = 0; n < 4; n++)
		begin
			for (int i = 0; i < 11; i++)
			begin
				written[n][i] = $random(seed);
				writeEntry(8'(n*64 + i*4), written[n][i], nnPkg::respOkay);
			end
		end
		writeEntry(8'h2C, 32'h1234_5678, nnPkg::respSlvErr);
		writeEntry(8'h41, 32'h0000_0055, nnPkg::respSlvErr);
		for (int n = 0; n < 4; n++)
		begin
			for (int i = 0; i < 10; i++)
				readEntry(8'(n*64 + i*4), {{24{written[n][i][7]}}, written[n][i][7:0]},
					nnPkg::respOkay);
			readEntry(8'(n*64 + 40), {{16{written[n][10][15]}}, written[n][10][15:0]},
				nnPkg::respOkay);
		end
		readEntry(8'h2C, 32'h0, nnPkg::respSlvErr);
		readEntry(8'hFC, 32'h0, nnPkg::respSlvErr);
		// back-to-back burst on the new coefficients
		for (int k = 0; k < 20; k++)
			vectorEntry(randomVec());
		cycleLimit = numEntries * 10 + 50;

		repeat (4) @(negedge clk);
		reset = 1'b0;
		prevVector = 1'b0;
		for (int e = 0; e < numEntries; e++)
		begin
			expData = datas[e];
			expResp = resps[e];
			case (kinds[e])
				entVector:
				begin
					inVec = vecs[e];
					inValid = 1'b1;
					@(negedge clk);
					inValid = 1'b0;
				end
				entWrite:
				begin
					if (prevVector)
						repeat (3) @(negedge clk); // let the pipeline drain
					regWrite(addrs[e], datas[e]);
				end
				default:
					busRead(addrs[e]);
			endcase
			prevVector = (kinds[e] == entVector);
		end
		while (pending != 0)
			@(negedge clk); // vectors still in flight
		$display("checks: %0d, errors: %0d, assertion failures: %0d", checks, errors,
			dut0.asserts0.failures);
		if (errors == 0 && dut0.asserts0.failures == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

// ==== verilog.f ====
design/nnPkg.sv
design/axiLiteIf.sv
design/neuronCore.sv
design/denseLayer.sv
design/layerRegs.sv
design/layerTop.sv
tb/layerTop_asserts.sv
tb/layerChecker.sv
tb/layerTb.sv

// ==== Makefile ====
TOP = layerTb
OBJ = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module $(TOP) -Mdir $(OBJ)

run: compile
	@out=$$(./$(OBJ)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf $(OBJ)
